/* all.f */
+incdir+.
rvPkg.sv
rvDecoder.sv
rvImmGen.sv
rvRegFile.sv
rvAlu.sv
rvPcUnit.sv
rvCore.sv
rvCoreTb.sv

/* rvAlu.sv */
// ALU: add/sub, logic, shift left, compares, upper-immediate and jalr target
`default_nettype none
`timescale 1ns/10ps

`include "rv_config.svh"

module rvAlu (
  input  rvPkg::aluOp    i_op,
  input  rvPkg::xlenWord i_a,
  input  rvPkg::xlenWord i_b,
  input  rvPkg::xlenWord i_pc,
  output rvPkg::xlenWord o_result
);
  import rvPkg::*;

  localparam int shamtW = $clog2(`RV_XLEN);

  xlenWord           sum;
  logic [shamtW-1:0] shamt;
  logic              ltSigned;
  logic              ltUnsigned;

  assign sum        = i_a + i_b; // shared by add, lw/sw address and jalr
  assign shamt      = i_b[shamtW-1:0];
  assign ltSigned   = $signed(i_a) < $signed(i_b);
  assign ltUnsigned = i_a < i_b;

  always_comb begin
    case (i_op)
      aluAdd:   o_result = sum;
      aluSub:   o_result = i_a - i_b;
      aluAnd:   o_result = i_a & i_b;
      aluOr:    o_result = i_a | i_b;
      aluXor:   o_result = i_a ^ i_b;
      aluSll:   o_result = i_a << shamt;
      aluSlt:   o_result = xlenWord'(ltSigned);
      aluSltu:  o_result = xlenWord'(ltUnsigned);
      aluEq:    o_result = xlenWord'(i_a == i_b); // branch conditions
      aluNe:    o_result = xlenWord'(i_a != i_b);
      aluPassB: o_result = i_b;         // lui
      aluPcAdd: o_result = i_pc + i_b;  // auipc
      aluJalr: begin
        o_result    = sum;
        o_result[0] = 1'b0;
      end
      default:  o_result = sum;
    endcase
  end

endmodule

`default_nettype wire

/* rvCore.sv */
// single-cycle RV32I subset core: decoder, immediates, registers, ALU, PC and memory ports
`default_nettype none
`timescale 1ns/10ps

module rvCore (
  input  wire             clk,
  input  wire             rst,
  input  rvPkg::instrWord i_instr,
  output rvPkg::xlenWord  o_pc,
  input  rvPkg::xlenWord  i_memRdata,
  output rvPkg::memReq    o_memReq
);
  import rvPkg::*;

  ctrlBundle ctrl;
  xlenWord   imm;
  xlenWord   rs1Data;
  xlenWord   rs2Data;
  xlenWord   aluB;
  xlenWord   aluResult;
  xlenWord   linkValue;
  xlenWord   wbData;

  rvDecoder uDecoder (
    .i_instr (i_instr),
    .o_ctrl  (ctrl)
  );

  rvImmGen uImmGen (
    .i_instr (i_instr),
    .i_kind  (ctrl.immKind),
    .o_imm   (imm)
  );

  rvRegFile uRegFile (
    .clk         (clk),
    .rst         (rst),
    .i_writeEn   (ctrl.regWrite),
    .i_writeIdx  (i_instr.rFmt.rd),
    .i_writeData (wbData),
    .i_readIdxA  (i_instr.rFmt.rs1),
    .i_readIdxB  (i_instr.rFmt.rs2),
    .o_readDataA (rs1Data),
    .o_readDataB (rs2Data)
  );

  assign aluB = ctrl.aluSrcImm ? imm : rs2Data;

  rvAlu uAlu (
    .i_op     (ctrl.aluOp),
    .i_a      (rs1Data),
    .i_b      (aluB),
    .i_pc     (o_pc),
    .o_result (aluResult)
  );

  rvPcUnit uPcUnit (
    .clk         (clk),
    .rst         (rst),
    .i_sel       (ctrl.nextPc),
    .i_imm       (imm),
    .i_aluResult (aluResult),
    .o_pc        (o_pc),
    .o_link      (linkValue)
  );

  // write-back source
  always_comb begin
    case (ctrl.wbSel)
      wbMem:   wbData = i_memRdata; // lw
      wbLink:  wbData = linkValue;  // jal, jalr
      default: wbData = aluResult;
    endcase
  end

  // store port, no write while held in reset
  assign o_memReq = '{wrStrobe: ctrl.memWrite & ~rst, addr: aluResult, wdata: rs2Data};

endmodule

`default_nettype wire

/* rvCoreTb.sv */
// rvCore testbench with clock, reset, memory models, encoders, directed tests, checker and watchdog
`default_nettype none
`timescale 1ns/10ps

`include "rv_config.svh"

module rvCoreTb;
  import rvPkg::*;

  localparam time clkPeriod = 40ns;
  localparam int memWords = 256;
  localparam logic [6:0] opImm = 7'b0010011;

  logic     clk;
  logic     rst;
  instrWord instr;
  xlenWord  pc;
  xlenWord  memRdata;
  memReq    req;

  logic [31:0] imem [memWords];
  logic [31:0] dmem [memWords];
  logic [31:0] prog [$];
  xlenWord     expTrace [$]; // fetch address of every executed instruction
  xlenWord     expAddr [$];
  xlenWord     expData [$];
  xlenWord     logAddr [$];
  xlenWord     logData [$];
  int          seed = 91687;
  int          budgetCycles = 0;
  int          elapsedCycles = 0;

  rvCore uut (.clk(clk), .rst(rst), .i_instr(instr), .o_pc(pc),
              .i_memRdata(memRdata), .o_memReq(req));

  // word-addressed memories with combinational reads
  assign instr    = imem[pc[9:2]];
  assign memRdata = dmem[req.addr[9:2]];

  always @(posedge clk) begin
    if (req.wrStrobe) begin
      dmem[req.addr[9:2]] <= req.wdata;
      logAddr.push_back(req.addr);
      logData.push_back(req.wdata);
    end
  end

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  function automatic logic [31:0] encR(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
  endfunction

  function automatic logic [31:0] encI(logic [11:0] imm, int rs1, logic [2:0] f3, int rd,
                                       logic [6:0] op);
    return {imm, 5'(rs1), f3, 5'(rd), op};
  endfunction

  function automatic logic [31:0] encS(logic [11:0] imm, int rs2, int rs1);
    return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], 7'b0100011}; // sw
  endfunction

  function automatic logic [31:0] encB(logic [12:0] imm, int rs2, int rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] encU(logic [19:0] imm, int rd, logic [6:0] op);
    return {imm, 5'(rd), op};
  endfunction

  function automatic logic [31:0] encJ(logic [20:0] imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'b1101111};
  endfunction

  function automatic xlenWord dataPattern(int idx);
    return 32'h5EED_0000 ^ (idx * 32'h0102_0409) ^ (idx << 24);
  endfunction

  function automatic logic branchTaken(logic [2:0] f3, xlenWord a, xlenWord b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      default: return a < b;
    endcase
  endfunction

  task automatic checkEq(string name, xlenWord expected, xlenWord actual);
    if (expected !== actual) begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      $display("TESTS FAILED");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // unused code is addi x0, x0, index so a stray fetch is a no-op
  task automatic fillMemories();
    for (int i = 0; i < memWords; i++) begin
      imem[i] = (i < prog.size()) ? prog[i] : encI(12'(i), 0, 3'b000, 0, opImm);
      dmem[i] = dataPattern(i);
    end
  endtask

  task automatic emit(logic [31:0] word);
    expTrace.push_back(xlenWord'(prog.size() * 4));
    prog.push_back(word);
  endtask

  task automatic emitSkipped(logic [31:0] word);
    prog.push_back(word); // stepped over by a branch or jump
  endtask

  task automatic expectStore(xlenWord addr, xlenWord data);
    expAddr.push_back(addr);
    expData.push_back(data);
  endtask

  // lui then addi with the upper half rounded for the sign of the low 12 bits
  task automatic loadConst(int rd, xlenWord value);
    xlenWord upper;
    upper = value + 32'h800;
    emit(encU(upper[31:12], rd, 7'b0110111));
    emit(encI(value[11:0], rd, 3'b000, rd, opImm));
  endtask

  task automatic storeCheck(int rs, xlenWord expected);
    xlenWord addr;
    addr = 32'h200 + expAddr.size() * 4; // next free log slot
    emit(encS(addr[11:0], rs, 0));
    expectStore(addr, expected);
  endtask

  task automatic aluStep(logic [31:0] word, xlenWord expected);
    emit(word);
    storeCheck(3, expected);
  endtask

  // loads the program plus a halt loop, resets, then follows the PC to the halt
  task automatic runProgram(string name, int resetCycles);
    @(posedge clk);
    #2 rst = 1'b1;
    emit(encJ(21'd0, 0)); // jal x0, 0
    fillMemories();
    logAddr.delete();
    logData.delete();
    budgetCycles += resetCycles + expTrace.size() + 1;
    repeat (resetCycles) begin
      @(negedge clk);
      checkEq({name, " reset pc"}, `RV_RESET_PC, pc);
      checkEq({name, " reset strobe"}, 32'd0, 32'(req.wrStrobe));
    end
    @(posedge clk);
    #2 rst = 1'b0;
    foreach (expTrace[i]) begin
      @(negedge clk);
      checkEq({name, " pc"}, expTrace[i], pc);
    end
    checkEq({name, " store count"}, expAddr.size(), logAddr.size());
    foreach (expAddr[i]) begin
      checkEq({name, " store addr"}, expAddr[i], logAddr[i]);
      checkEq({name, " store data"}, expData[i], logData[i]);
    end
    prog.delete();
    expTrace.delete();
    expAddr.delete();
    expData.delete();
  endtask

  task automatic resetSequenceTest();
    storeCheck(0, 32'd0); // a store sits at the reset PC
    emit(encI(12'd0, 0, 3'b000, 0, opImm));
    emit(encI(12'd7, 1, 3'b000, 1, opImm));
    emit(encI(12'd5, 1, 3'b000, 1, 7'b0001011)); // custom-0 opcode writes nothing
    emit(encI(12'd7, 1, 3'b000, 1, opImm));
    emit(encR(7'h00, 1, 1, 3'b000, 2));
    storeCheck(2, 32'd28);
    runProgram("reset", 16);
  endtask

  task automatic aluTest();
    xlenWord     a;
    xlenWord     b;
    xlenWord     sImm;
    logic [11:0] imm;
    logic [4:0]  sh;
    for (int round = 0; round < 3; round++) begin
      a = $random(seed);
      b = $random(seed);
      imm = $random(seed);
      sh = $random(seed);
      sImm = {{20{imm[11]}}, imm};
      loadConst(1, a);
      loadConst(2, b);
      aluStep(encR(7'h00, 2, 1, 3'b000, 3), a + b);
      aluStep(encR(7'h20, 2, 1, 3'b000, 3), a - b);
      aluStep(encR(7'h00, 2, 1, 3'b111, 3), a & b);
      aluStep(encR(7'h00, 2, 1, 3'b110, 3), a | b);
      aluStep(encR(7'h00, 2, 1, 3'b100, 3), a ^ b);
      aluStep(encR(7'h00, 2, 1, 3'b001, 3), a << b[4:0]);
      aluStep(encR(7'h00, 2, 1, 3'b010, 3), xlenWord'($signed(a) < $signed(b)));
      aluStep(encR(7'h00, 2, 1, 3'b011, 3), xlenWord'(a < b));
      aluStep(encI(imm, 1, 3'b000, 3, opImm), a + sImm);
      aluStep(encI(imm, 1, 3'b111, 3, opImm), a & sImm);
      aluStep(encI(imm, 1, 3'b110, 3, opImm), a | sImm);
      aluStep(encI(imm, 1, 3'b100, 3, opImm), a ^ sImm);
      aluStep(encI(imm, 1, 3'b010, 3, opImm), xlenWord'($signed(a) < $signed(sImm)));
      aluStep(encI(imm, 1, 3'b011, 3, opImm), xlenWord'(a < sImm));
      aluStep(encI({7'b0, sh}, 1, 3'b001, 3, opImm), a << sh);
    end
    emit(encI(12'h123, 1, 3'b000, 0, opImm)); // write to x0 is dropped
    storeCheck(0, 32'd0);
    runProgram("alu", 4);
  endtask

  task automatic loadTest();
    loadConst(5, 32'h40);
    emit(encI(12'd8, 5, 3'b010, 6, 7'b0000011));
    emit(encS(12'h1C0, 6, 5));
    expectStore(32'h40 + 32'h1C0, dataPattern((32'h40 + 8) >> 2));
    loadConst(7, 32'h3F0);
    emit(encI(12'hFF4, 7, 3'b010, 8, 7'b0000011)); // offset -12
    emit(encS(12'hF00, 8, 7));                      // offset -256
    expectStore(32'h3F0 - 32'h100, dataPattern((32'h3F0 - 12) >> 2));
    runProgram("load", 4);
  endtask

  task automatic branchTest();
    xlenWord     pa [3];
    xlenWord     pb [3];
    xlenWord     r;
    logic [2:0]  funcs [4];
    logic        taken;
    logic [31:0] filler;
    r = $random(seed);
    pa = '{32'hFFFF_FFFB, 32'd3, r};
    pb = '{32'd3, 32'hFFFF_FFFB, r};
    funcs = '{3'b000, 3'b001, 3'b100, 3'b110}; // beq, bne, blt, bltu
    filler = encI(12'd1, 3, 3'b000, 3, opImm);
    for (int f = 0; f < 4; f++) begin
      for (int p = 0; p < 3; p++) begin
        loadConst(1, pa[p]);
        loadConst(2, pb[p]);
        taken = branchTaken(funcs[f], pa[p], pb[p]);
        emit(encB(13'd12, 2, 1, funcs[f]));
        repeat (2) begin
          if (taken) emitSkipped(filler);
          else emit(filler);
        end
      end
    end
    runProgram("branch", 4);
  endtask

  task automatic jumpTest();
    xlenWord     target;
    xlenWord     link;
    logic [31:0] filler;
    filler = encI(12'd1, 3, 3'b000, 3, opImm);
    link = prog.size() * 4 + 4;
    emit(encJ(21'd16, 1));
    repeat (3) emitSkipped(filler);
    storeCheck(1, link);
    target = (prog.size() + 2) * 4 + 12; // jalr sits after the two loadConst words
    loadConst(5, target - 2);
    emit(encI(12'd3, 5, 3'b000, 6, 7'b1100111)); // odd sum with bit 0 cleared
    repeat (2) emitSkipped(filler);
    storeCheck(6, target - 12 + 4);
    runProgram("jump", 4);
  endtask

  task automatic upperTest();
    logic [19:0] up;
    xlenWord     pcNow;
    for (int k = 0; k < 3; k++) begin
      up = $random(seed);
      emit(encU(up, 3, 7'b0110111));
      storeCheck(3, {up, 12'h000});
      pcNow = prog.size() * 4;
      emit(encU(up ^ 20'h5A5A5, 4, 7'b0010111));
      storeCheck(4, {up ^ 20'h5A5A5, 12'h000} + pcNow);
    end
    runProgram("upper", 4);
  endtask

  initial begin
    rst = 1'b1;
    fillMemories();
    resetSequenceTest();
    aluTest();
    loadTest();
    branchTest();
    jumpTest();
    upperTest();
    $display("TESTS PASSED");
    $finish;
  end

  // limit is twice the cycle budget of the programs started so far
  initial begin
    while (elapsedCycles <= 2 * budgetCycles + 2) begin
      @(posedge clk);
      elapsedCycles++;
    end
    $display("run timed out after %0d clock cycles", elapsedCycles);
    $display("TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

/* rvDecoder.sv */
// instruction decoder: opcode/funct fields to the control bundle
`default_nettype none
`timescale 1ns/10ps

module rvDecoder (
  input  rvPkg::instrWord  i_instr,
  output rvPkg::ctrlBundle o_ctrl
);
  import rvPkg::*;

  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opAuipc  = 7'b0010111;
  localparam logic [6:0] opReg    = 7'b0110011;
  localparam logic [6:0] opImm    = 7'b0010011;
  localparam logic [6:0] opLoad   = 7'b0000011;
  localparam logic [6:0] opStore  = 7'b0100011;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opJal    = 7'b1101111;
  localparam logic [6:0] opJalr   = 7'b1100111;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = i_instr.rFmt.opcode;
  assign funct3 = i_instr.rFmt.funct3;
  assign funct7 = i_instr.rFmt.funct7; // also the upper imm bits of slli

  always_comb begin
    // no-op unless a known encoding matches
    o_ctrl = '{regWrite: 1'b0, memWrite: 1'b0, aluSrcImm: 1'b0, aluOp: aluAdd,
               immKind: immNone, nextPc: pcPlus4, wbSel: wbAlu};
    case (opcode)
      opLui: begin
        o_ctrl = '{1'b1, 1'b0, 1'b1, aluPassB, immU, pcPlus4, wbAlu};
      end
      opAuipc: begin
        o_ctrl = '{1'b1, 1'b0, 1'b1, aluPcAdd, immU, pcPlus4, wbAlu};
      end
      opReg: begin
        o_ctrl.regWrite = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: o_ctrl.aluOp = aluAdd;
          10'b0100000_000: o_ctrl.aluOp = aluSub;
          10'b0000000_111: o_ctrl.aluOp = aluAnd;
          10'b0000000_110: o_ctrl.aluOp = aluOr;
          10'b0000000_100: o_ctrl.aluOp = aluXor;
          10'b0000000_001: o_ctrl.aluOp = aluSll;
          10'b0000000_010: o_ctrl.aluOp = aluSlt;
          10'b0000000_011: o_ctrl.aluOp = aluSltu;
          default:         o_ctrl.regWrite = 1'b0; // srl, sra and the rest
        endcase
      end
      opImm: begin
        o_ctrl.regWrite  = 1'b1;
        o_ctrl.aluSrcImm = 1'b1;
        o_ctrl.immKind   = immI;
        case (funct3)
          3'b000: o_ctrl.aluOp = aluAdd;
          3'b111: o_ctrl.aluOp = aluAnd;
          3'b110: o_ctrl.aluOp = aluOr;
          3'b100: o_ctrl.aluOp = aluXor;
          3'b010: o_ctrl.aluOp = aluSlt;
          3'b011: o_ctrl.aluOp = aluSltu;
          3'b001: begin
            o_ctrl.aluOp    = aluSll;
            o_ctrl.immKind  = immShamt;
            o_ctrl.regWrite = (funct7 == 7'b0000000);
          end
          default: o_ctrl.regWrite = 1'b0;
        endcase
      end
      opLoad: begin
        if (funct3 == 3'b010) // lw only
          o_ctrl = '{1'b1, 1'b0, 1'b1, aluAdd, immI, pcPlus4, wbMem};
      end
      opStore: begin
        if (funct3 == 3'b010) // sw only
          o_ctrl = '{1'b0, 1'b1, 1'b1, aluAdd, immS, pcPlus4, wbAlu};
      end
      opBranch: begin
        o_ctrl.immKind = immB;
        o_ctrl.nextPc  = pcBranch;
        case (funct3)
          3'b000:  o_ctrl.aluOp = aluEq;
          3'b001:  o_ctrl.aluOp = aluNe;
          3'b100:  o_ctrl.aluOp = aluSlt;
          3'b110:  o_ctrl.aluOp = aluSltu;
          default: o_ctrl.nextPc = pcPlus4; // bge/bgeu fall through
        endcase
      end
      opJal: begin
        o_ctrl = '{1'b1, 1'b0, 1'b0, aluAdd, immJ, pcJal, wbLink};
      end
      opJalr: begin
        if (funct3 == 3'b000)
          o_ctrl = '{1'b1, 1'b0, 1'b1, aluJalr, immI, pcJalr, wbLink};
      end
      default: ;
    endcase
  end

  // a store must never also update the register file
  storeNoRegWrite: assert final (!(o_ctrl.memWrite && o_ctrl.regWrite))
    else $error("decoder raised regWrite on a store, instr %h", i_instr);

endmodule

`default_nettype wire

/* rvImmGen.sv */
// immediate generator for the I, shamt, S, B, U and J formats
`default_nettype none
`timescale 1ns/10ps

`include "rv_config.svh"

module rvImmGen (
  input  rvPkg::instrWord i_instr,
  input  rvPkg::immKind   i_kind,
  output rvPkg::xlenWord  o_imm
);
  import rvPkg::*;

  always_comb begin
    case (i_kind)
      immI: begin
        o_imm = {{(`RV_XLEN-12){i_instr.iFmt.imm11_0[11]}}, i_instr.iFmt.imm11_0};
      end
      immShamt: begin
        o_imm = xlenWord'(i_instr.iFmt.imm11_0[4:0]); // zero-extended
      end
      immS: begin
        o_imm = {{(`RV_XLEN-12){i_instr.sFmt.imm11_5[6]}},
                 i_instr.sFmt.imm11_5, i_instr.sFmt.imm4_0};
      end
      immB: begin
        // 13-bit offset, low bit always zero
        o_imm = {{(`RV_XLEN-13){i_instr.bFmt.imm12}}, i_instr.bFmt.imm12,
                 i_instr.bFmt.imm11, i_instr.bFmt.imm10_5, i_instr.bFmt.imm4_1, 1'b0};
      end
      immU: begin
        o_imm = xlenWord'({i_instr.uFmt.imm31_12, 12'b0});
      end
      immJ: begin
        // 21-bit offset, low bit always zero
        o_imm = {{(`RV_XLEN-21){i_instr.jFmt.imm20}}, i_instr.jFmt.imm20,
                 i_instr.jFmt.imm19_12, i_instr.jFmt.imm11, i_instr.jFmt.imm10_1, 1'b0};
      end
      default: begin
        o_imm = '0; // immNone
      end
    endcase
  end

endmodule

`default_nettype wire

/* rvPcUnit.sv */
// PC register with next-PC selection and link value
`default_nettype none
`timescale 1ns/10ps

`include "rv_config.svh"

module rvPcUnit (
  input  wire              clk,
  input  wire              rst,
  input  rvPkg::nextPcSel  i_sel,
  input  rvPkg::xlenWord   i_imm,
  input  rvPkg::xlenWord   i_aluResult,
  output rvPkg::xlenWord   o_pc,
  output rvPkg::xlenWord   o_link
);
  import rvPkg::*;

  localparam int alignBits = $clog2(`RV_INSTR_BYTES);

  xlenWord pcQ;
  xlenWord pcTarget;
  xlenWord pcNext;
  logic    branchTaken;

  assign o_pc        = pcQ;
  assign o_link      = pcQ + `RV_INSTR_BYTES; // also the sequential next PC
  assign pcTarget    = pcQ + i_imm;
  assign branchTaken = (i_aluResult == xlenWord'(1)); // condition from ALU

  always_comb begin
    case (i_sel)
      pcBranch: pcNext = branchTaken ? pcTarget : o_link;
      pcJal:    pcNext = pcTarget;
      pcJalr:   pcNext = i_aluResult; // bit 0 already cleared
      default:  pcNext = o_link;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pcQ <= `RV_RESET_PC;
    end else begin
      pcQ <= pcNext;
    end
  end

  // targets from imm and jalr must keep the fetch address word aligned
  pcAligned: assert property (
    @(posedge clk) disable iff (rst) (o_pc[alignBits-1:0] == '0)
  ) else $error("misaligned PC %h", o_pc);

endmodule

`default_nettype wire

/* rvPkg.sv */
// core types: instruction word union, ALU/imm/next-PC/write-back enums, control and memory structs
`default_nettype none

`include "rv_config.svh"

package rvPkg;

  typedef logic [`RV_XLEN-1:0] xlenWord;
  typedef logic [`RV_REG_IDX_W-1:0] regIdx;

  // encoded field positions, msb first
  typedef struct packed {
    logic [6:0] funct7;
    regIdx      rs2;
    regIdx      rs1;
    logic [2:0] funct3;
    regIdx      rd;
    logic [6:0] opcode;
  } rFmtFields;

  typedef struct packed {
    logic [11:0] imm11_0;
    regIdx       rs1;
    logic [2:0]  funct3;
    regIdx       rd;
    logic [6:0]  opcode;
  } iFmtFields;

  typedef struct packed {
    logic [6:0] imm11_5;
    regIdx      rs2;
    regIdx      rs1;
    logic [2:0] funct3;
    logic [4:0] imm4_0;
    logic [6:0] opcode;
  } sFmtFields;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    regIdx      rs2;
    regIdx      rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } bFmtFields;

  typedef struct packed {
    logic [19:0] imm31_12;
    regIdx       rd;
    logic [6:0]  opcode;
  } uFmtFields;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    regIdx      rd;
    logic [6:0] opcode;
  } jFmtFields;

  // one fetched word seen through every format
  typedef union packed {
    rFmtFields rFmt;
    iFmtFields iFmt;
    sFmtFields sFmt;
    bFmtFields bFmt;
    uFmtFields uFmt;
    jFmtFields jFmt;
  } instrWord;

  typedef enum logic [3:0] {
    aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSll, aluSlt, aluSltu,
    aluEq, aluNe, aluPassB, aluPcAdd, aluJalr
  } aluOp;

  typedef enum logic [2:0] {immI, immShamt, immS, immB, immU, immJ, immNone} immKind;

  typedef enum logic [1:0] {pcPlus4, pcBranch, pcJal, pcJalr} nextPcSel;

  typedef enum logic [1:0] {wbAlu, wbMem, wbLink} wbSel;

  typedef struct packed {
    logic     regWrite;
    logic     memWrite;
    logic     aluSrcImm; // operand B from immediate
    aluOp     aluOp;
    immKind   immKind;
    nextPcSel nextPc;
    wbSel     wbSel;
  } ctrlBundle;

  typedef struct packed {
    logic    wrStrobe;
    xlenWord addr;
    xlenWord wdata;
  } memReq;

endpackage

`default_nettype wire

/* rvRegFile.sv */
// register file: two combinational read ports, one write port, x0 fixed at zero
`default_nettype none
`timescale 1ns/10ps

`include "rv_config.svh"

module rvRegFile (
  input  wire            clk,
  input  wire            rst,
  input  wire            i_writeEn,
  input  rvPkg::regIdx   i_writeIdx,
  input  rvPkg::xlenWord i_writeData,
  input  rvPkg::regIdx   i_readIdxA,
  input  rvPkg::regIdx   i_readIdxB,
  output rvPkg::xlenWord o_readDataA,
  output rvPkg::xlenWord o_readDataB
);
  import rvPkg::*;

  xlenWord regs [`RV_REG_COUNT];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < `RV_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (i_writeEn && (i_writeIdx != '0)) begin
      regs[i_writeIdx] <= i_writeData; // x0 writes dropped here
    end
  end

  // reads see the old value until the edge
  assign o_readDataA = regs[i_readIdxA];
  assign o_readDataB = regs[i_readIdxB];

  // x0 stays zero on both ports whatever was written earlier
  x0ReadsZero: assert property (
    @(posedge clk) disable iff (rst)
      ((i_readIdxA == '0) |-> (o_readDataA == '0)) and
      ((i_readIdxB == '0) |-> (o_readDataB == '0))
  ) else $error("x0 read back non-zero");

endmodule

`default_nettype wire

/* rv_config.svh */
// core width, register file size, reset PC and instruction size defines
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data and address width
`define RV_XLEN 32

// architectural registers x0 .. x31
`define RV_REG_COUNT 32
`define RV_REG_IDX_W 5

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// one instruction word, also the PC step and link offset
`define RV_INSTR_BYTES 4

`endif
